/* rtl/timer_params.svh */
`ifndef TIMER_PARAMS_SVH
`define TIMER_PARAMS_SVH

// Number of timer channels from 1 to 3
`define TMR_NUM_CH      2

// Address is {channel[1:0], register[2:0]}
`define TMR_ADDR_W      5

// Per-channel register offsets
`define TMR_REG_CTRL    3'd0   // [1:0] mode, [2] start
`define TMR_REG_PRESC   3'd1
`define TMR_REG_RELOAD  3'd2
`define TMR_REG_COMPARE 3'd3
`define TMR_REG_COUNT   3'd4   // Read only

// Channel field value for the global registers
`define TMR_GLOBAL_CH   2'd3
`define TMR_REG_STATUS  3'd0   // Write one to clear
`define TMR_REG_IRQ_EN  3'd1

`endif

/* rtl/timer_pkg.sv */
`include "timer_params.svh"

package timer_pkg;

    // Counter, reload and compare values
    typedef logic [31:0] count_t;

    // Prescaler divide value
    typedef logic [15:0] presc_t;

    // Register data word
    typedef logic [31:0] word_t;

    // Register address
    typedef logic [`TMR_ADDR_W-1:0] addr_t;

    // Channel operating mode as held in CTRL[1:0]
    typedef enum logic [1:0] {
        MODE_OFF      = 2'b00,
        MODE_ONESHOT  = 2'b01,
        MODE_PERIODIC = 2'b10,
        MODE_PWM      = 2'b11
    } tmr_mode_e;

endpackage

/* rtl/timer_reg_decode.sv */
`timescale 1ns/1ns
`include "timer_params.svh"

module timer_reg_decode
    import timer_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wr_en,
    input  logic                   rd_en,
    input  addr_t                  addr,
    input  word_t                  wdata,
    output tmr_mode_e              mode        [`TMR_NUM_CH],
    output logic [`TMR_NUM_CH-1:0] start,
    output logic [`TMR_NUM_CH-1:0] start_pulse,
    output presc_t                 prescaler   [`TMR_NUM_CH],
    output count_t                 reload_val  [`TMR_NUM_CH],
    output count_t                 compare_val [`TMR_NUM_CH],
    output logic                   status_clr_wr,
    output logic                   irq_en_wr,
    output word_t                  cfg_rdata
);

    logic [1:0]             ch_sel;
    logic [2:0]             reg_sel;
    logic [`TMR_NUM_CH-1:0] start_d;   // Start bits one cycle back

    assign ch_sel  = addr[`TMR_ADDR_W-1:`TMR_ADDR_W-2];
    assign reg_sel = addr[2:0];

    // Setup registers, written on the strobe edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `TMR_NUM_CH; i++) begin
                mode[i]        <= MODE_OFF;
                prescaler[i]   <= '0;
                reload_val[i]  <= '0;
                compare_val[i] <= '0;
            end
            start   <= '0;
            start_d <= '0;
        end else begin
            start_d <= start;
            for (int i = 0; i < `TMR_NUM_CH; i++) begin
                if (wr_en && ch_sel == 2'(i)) begin
                    case (reg_sel)
                        `TMR_REG_CTRL: begin
                            mode[i]  <= tmr_mode_e'(wdata[1:0]);
                            start[i] <= wdata[2];
                        end
                        `TMR_REG_PRESC:   prescaler[i]   <= wdata[15:0];
                        `TMR_REG_RELOAD:  reload_val[i]  <= wdata;
                        `TMR_REG_COMPARE: compare_val[i] <= wdata;
                        default: ;  // COUNT is read only
                    endcase
                end
            end
        end
    end

    // One-shot trigger on a 0 to 1 start edge
    assign start_pulse = start & ~start_d;

    // Global registers live in the result block
    assign status_clr_wr = wr_en && (ch_sel == `TMR_GLOBAL_CH) &&
                           (reg_sel == `TMR_REG_STATUS);
    assign irq_en_wr     = wr_en && (ch_sel == `TMR_GLOBAL_CH) &&
                           (reg_sel == `TMR_REG_IRQ_EN);

    // Setup readback where unmapped locations read zero
    always_comb begin
        cfg_rdata = '0;
        for (int i = 0; i < `TMR_NUM_CH; i++) begin
            if (ch_sel == 2'(i)) begin
                case (reg_sel)
                    `TMR_REG_CTRL:    cfg_rdata = word_t'({start[i], mode[i]});
                    `TMR_REG_PRESC:   cfg_rdata = word_t'(prescaler[i]);
                    `TMR_REG_RELOAD:  cfg_rdata = reload_val[i];
                    `TMR_REG_COMPARE: cfg_rdata = compare_val[i];
                    default:          cfg_rdata = '0;
                endcase
            end
        end
    end

    // The port has a single address, so access is one way per cycle
    a_no_rd_wr_overlap: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(wr_en && rd_en)
    ) else $error("read and write strobes high in the same cycle");

endmodule

/* rtl/timer_channel.sv */
`timescale 1ns/1ns
`include "timer_params.svh"

module timer_channel
    import timer_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  tmr_mode_e mode,
    input  logic      start,
    input  logic      start_pulse,
    input  presc_t    prescaler,
    input  count_t    reload_val,
    input  count_t    compare_val,
    output logic      timeout,
    output logic      pwm_out,
    output count_t    current_count
);

    presc_t prescale_cnt;   // Divider for the PWM tick
    logic   pwm_tick;
    count_t pwm_next;       // PWM count after the next tick
    count_t per_next;       // Periodic count after this cycle

    assign pwm_tick = (prescale_cnt >= prescaler);

    // Up count from 0 to reload-1, then wrap
    assign pwm_next = (current_count < reload_val - 1'b1) ? current_count + 1'b1 : '0;

    // Down count with auto reload at zero
    assign per_next = (current_count == '0) ? reload_val : current_count - 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            current_count <= '0;
            prescale_cnt  <= '0;
            timeout       <= 1'b0;
            pwm_out       <= 1'b0;
        end else if (!start) begin
            // Stopped channel holds everything at zero
            current_count <= '0;
            prescale_cnt  <= '0;
            timeout       <= 1'b0;
            pwm_out       <= 1'b0;
        end else begin
            case (mode)
                MODE_ONESHOT: begin
                    if (start_pulse && current_count == '0) begin
                        current_count <= reload_val;
                        timeout       <= 1'b0;
                    end else if (current_count != '0) begin
                        current_count <= current_count - 1'b1;
                        timeout       <= (current_count == 32'd1);  // Lands on zero
                    end else begin
                        timeout       <= 1'b0;   // Expired until the next trigger
                    end
                    prescale_cnt <= '0;
                    pwm_out      <= 1'b0;
                end

                MODE_PERIODIC: begin
                    current_count <= per_next;
                    timeout       <= (per_next == '0);
                    prescale_cnt  <= '0;
                    pwm_out       <= 1'b0;
                end

                MODE_PWM: begin
                    if (pwm_tick) begin
                        prescale_cnt  <= '0;
                        current_count <= pwm_next;
                        pwm_out       <= (pwm_next < compare_val);
                        // Held for a whole tick at the top of the period
                        timeout       <= (pwm_next == reload_val - 1'b1);
                    end else begin
                        prescale_cnt  <= prescale_cnt + 1'b1;
                    end
                end

                default: begin
                    current_count <= '0;
                    prescale_cnt  <= '0;
                    timeout       <= 1'b0;
                    pwm_out       <= 1'b0;
                end
            endcase
        end
    end

    // Outputs are registered, so they follow the mode of the previous cycle
    a_pwm_only_in_pwm: assert property (
        @(posedge clk) disable iff (!rst_n)
        ($past(mode) != MODE_PWM) |-> !pwm_out
    ) else $error("pwm_out high outside PWM mode");

    a_timeout_at_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        ($past(mode) inside {MODE_ONESHOT, MODE_PERIODIC} && timeout)
            |-> (current_count == '0)
    ) else $error("timeout with a nonzero count");

endmodule

/* rtl/timer_irq_result.sv */
`timescale 1ns/1ns
`include "timer_params.svh"

module timer_irq_result
    import timer_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`TMR_NUM_CH-1:0] timeout,
    input  count_t                 current_count [`TMR_NUM_CH],
    input  logic                   status_clr_wr,
    input  logic                   irq_en_wr,
    input  word_t                  wdata,
    input  logic                   rd_en,
    input  addr_t                  addr,
    input  word_t                  cfg_rdata,
    output logic                   irq,
    output word_t                  rdata,
    output logic                   rdata_valid
);

    logic [`TMR_NUM_CH-1:0] timeout_d;
    logic [`TMR_NUM_CH-1:0] status;
    logic [`TMR_NUM_CH-1:0] irq_en;
    logic [`TMR_NUM_CH-1:0] status_set;
    logic [`TMR_NUM_CH-1:0] status_clr;
    logic [1:0]             ch_sel;
    logic [2:0]             reg_sel;
    word_t                  rd_next;

    assign status_set = timeout & ~timeout_d;   // Rising edge only
    assign status_clr = status_clr_wr ? wdata[`TMR_NUM_CH-1:0] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timeout_d   <= '0;
            status      <= '0;
            irq_en      <= '0;
            irq         <= 1'b0;
            rdata_valid <= 1'b0;
        end else begin
            timeout_d   <= timeout;
            status      <= (status & ~status_clr) | status_set;   // Set wins
            if (irq_en_wr)
                irq_en  <= wdata[`TMR_NUM_CH-1:0];
            irq         <= |(status & irq_en);
            rdata_valid <= rd_en;
        end
    end

    assign ch_sel  = addr[`TMR_ADDR_W-1:`TMR_ADDR_W-2];
    assign reg_sel = addr[2:0];

    // Read source select
    always_comb begin
        rd_next = cfg_rdata;
        if (ch_sel == `TMR_GLOBAL_CH) begin
            case (reg_sel)
                `TMR_REG_STATUS: rd_next = word_t'(status);
                `TMR_REG_IRQ_EN: rd_next = word_t'(irq_en);
                default:         rd_next = '0;
            endcase
        end else if (reg_sel == `TMR_REG_COUNT) begin
            rd_next = '0;
            for (int i = 0; i < `TMR_NUM_CH; i++) begin
                if (ch_sel == 2'(i))
                    rd_next = current_count[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en)
            rdata <= rd_next;
    end

    a_irq_has_source: assert property (
        @(posedge clk) disable iff (!rst_n)
        irq |-> $past(|(status & irq_en))
    ) else $error("irq without an enabled status bit");

endmodule

/* rtl/timer_top.sv */
`timescale 1ns/1ns
`include "timer_params.svh"

module timer_top
    import timer_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wr_en,
    input  logic                   rd_en,
    input  addr_t                  addr,
    input  word_t                  wdata,
    output word_t                  rdata,
    output logic                   rdata_valid,
    output logic                   irq,
    output logic [`TMR_NUM_CH-1:0] pwm_out
);

    tmr_mode_e              mode          [`TMR_NUM_CH];
    presc_t                 prescaler     [`TMR_NUM_CH];
    count_t                 reload_val    [`TMR_NUM_CH];
    count_t                 compare_val   [`TMR_NUM_CH];
    count_t                 current_count [`TMR_NUM_CH];
    logic [`TMR_NUM_CH-1:0] start;
    logic [`TMR_NUM_CH-1:0] start_pulse;
    logic [`TMR_NUM_CH-1:0] timeout;
    logic                   status_clr_wr;
    logic                   irq_en_wr;
    word_t                  cfg_rdata;

    timer_reg_decode u_decode (
        .clk, .rst_n, .wr_en, .rd_en, .addr, .wdata,
        .mode, .start, .start_pulse, .prescaler, .reload_val, .compare_val,
        .status_clr_wr, .irq_en_wr, .cfg_rdata
    );

    for (genvar g = 0; g < `TMR_NUM_CH; g++) begin : g_ch
        timer_channel u_channel (
            .clk           (clk),
            .rst_n         (rst_n),
            .mode          (mode[g]),
            .start         (start[g]),
            .start_pulse   (start_pulse[g]),
            .prescaler     (prescaler[g]),
            .reload_val    (reload_val[g]),
            .compare_val   (compare_val[g]),
            .timeout       (timeout[g]),
            .pwm_out       (pwm_out[g]),
            .current_count (current_count[g])
        );
    end

    timer_irq_result u_result (
        .clk, .rst_n, .timeout, .current_count, .status_clr_wr, .irq_en_wr,
        .wdata, .rd_en, .addr, .cfg_rdata, .irq, .rdata, .rdata_valid
    );

endmodule

/* testbench/tb_timer.sv */
`timescale 1ns/1ns
`include "timer_params.svh"

module tb_timer
    import timer_pkg::*;
();

    localparam int    MAX_CYCLES  = 20000;   // Tests need well under 8000
    localparam word_t CH_MASK     = word_t'((1 << `TMR_NUM_CH) - 1);
    localparam addr_t STATUS_ADDR = {`TMR_GLOBAL_CH, `TMR_REG_STATUS};
    localparam addr_t IRQ_EN_ADDR = {`TMR_GLOBAL_CH, `TMR_REG_IRQ_EN};

    logic                   clk;
    logic                   rst_n;
    logic                   wr_en;
    logic                   rd_en;
    addr_t                  addr;
    word_t                  wdata;
    word_t                  rdata;
    logic                   rdata_valid;
    logic                   irq;
    logic [`TMR_NUM_CH-1:0] pwm_out;

    logic [31:0] rng_state;
    int          cycle_count;

    timer_top uut (
        .clk, .rst_n, .wr_en, .rd_en, .addr, .wdata,
        .rdata, .rdata_valid, .irq, .pwm_out
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "run stopped");
    endtask

    // Watchdog on the whole run
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
            abort_run("timeout: the tests did not finish within the cycle limit");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic addr_t reg_addr(input int ch, input logic [2:0] r);
        return {ch[1:0], r};
    endfunction

    // Bits that survive a write to each setup register
    function automatic word_t field_mask(input int r);
        case (r)
            0:       return 32'h0000_0007;   // start and mode
            1:       return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    task automatic check(input word_t actual, input word_t expected, input string msg);
        if (actual !== expected)
            abort_run($sformatf("mismatch at %0t: %s (got %0h, expected %0h)",
                                $time, msg, actual, expected));
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic reg_write(input addr_t a, input word_t d);
        wr_en = 1'b1;
        addr  = a;
        wdata = d;
        wait_cycles(1);
        wr_en = 1'b0;
        check(word_t'(rdata_valid), 32'h0, "rdata_valid high without a read");
    endtask

    task automatic reg_read(input addr_t a, output word_t d);
        int waited;
        waited = 0;
        rd_en  = 1'b1;
        addr   = a;
        wait_cycles(1);
        rd_en  = 1'b0;
        while (!rdata_valid) begin
            wait_cycles(1);
            waited++;
            if (waited > 16)
                abort_run("register read got no rdata_valid");
        end
        check(word_t'(waited), 32'h0, "rdata_valid not one cycle after rd_en");
        d = rdata;
    endtask

    task automatic stop_all();
        for (int ch = 0; ch < `TMR_NUM_CH; ch++)
            reg_write(reg_addr(ch, `TMR_REG_CTRL), '0);
        reg_write(IRQ_EN_ADDR, '0);
        reg_write(STATUS_ADDR, CH_MASK);
    endtask

    task automatic readback_regs();
        word_t wr_val [`TMR_NUM_CH][4];
        word_t en_val;
        word_t rd;
        for (int ch = 0; ch < `TMR_NUM_CH; ch++) begin
            for (int r = 0; r < 4; r++) begin
                wr_val[ch][r] = rand_word();
                reg_write(reg_addr(ch, 3'(r)), wr_val[ch][r]);
            end
        end
        en_val = rand_word();
        reg_write(IRQ_EN_ADDR, en_val);
        for (int ch = 0; ch < `TMR_NUM_CH; ch++) begin
            for (int r = 0; r < 4; r++) begin
                reg_read(reg_addr(ch, 3'(r)), rd);
                check(rd, wr_val[ch][r] & field_mask(r),
                      $sformatf("readback ch%0d reg%0d", ch, r));
            end
        end
        reg_read(IRQ_EN_ADDR, rd);
        check(rd, en_val & CH_MASK, "readback irq_en");
        stop_all();
    endtask

    task automatic oneshot_expiry();
        count_t n;
        word_t  rd;
        n = 32'd1 + rand_word() % 32'd50;
        reg_write(reg_addr(0, `TMR_REG_RELOAD), n);
        reg_write(reg_addr(0, `TMR_REG_CTRL), 32'h5);   // Start in one-shot mode
        wait_cycles(n - 1);
        reg_read(STATUS_ADDR, rd);
        check(rd, 32'h0, "one-shot status before expiry");
        wait_cycles(2);
        reg_read(STATUS_ADDR, rd);
        check(rd, 32'h1, "one-shot status after expiry");
        reg_read(reg_addr(0, `TMR_REG_COUNT), rd);
        check(rd, 32'h0, "one-shot count after expiry");

        // Restart by dropping and raising start
        reg_write(STATUS_ADDR, 32'h1);
        reg_write(reg_addr(0, `TMR_REG_CTRL), 32'h1);
        reg_write(reg_addr(0, `TMR_REG_CTRL), 32'h5);
        reg_read(STATUS_ADDR, rd);
        check(rd, 32'h0, "one-shot status after restart");
        wait_cycles(n + 1);
        reg_read(STATUS_ADDR, rd);
        check(rd, 32'h1, "one-shot status after second expiry");
        reg_write(STATUS_ADDR, 32'h1);
        reg_read(STATUS_ADDR, rd);
        check(rd, 32'h0, "one-shot status after clear");
        stop_all();
    endtask

    task automatic periodic_reload();
        count_t r_val;
        word_t  rd;
        int     k;
        int     elapsed;
        int     events;
        k       = 5;
        elapsed = 0;
        events  = 0;
        r_val   = 32'd6 + rand_word() % 32'd20;   // Period longer than one poll loop
        reg_write(reg_addr(0, `TMR_REG_RELOAD), r_val);
        reg_write(reg_addr(0, `TMR_REG_CTRL), 32'h6);   // Start in periodic mode
        while (elapsed < k * (int'(r_val) + 1)) begin
            reg_read(STATUS_ADDR, rd);
            elapsed++;
            if (rd[0]) begin
                events++;
                reg_write(STATUS_ADDR, 32'h1);
                elapsed++;
            end
            reg_read(reg_addr(0, `TMR_REG_COUNT), rd);
            elapsed++;
            check(word_t'(rd <= r_val), 32'h1, "periodic count above reload");
        end
        check(word_t'(events >= k - 1 && events <= k + 1), 32'h1,
              $sformatf("periodic event count %0d for %0d periods", events, k));
        stop_all();
    endtask

    task automatic pwm_duty();
        presc_t p;
        count_t r_val;
        count_t c_val;
        int     span;
        int     high;
        p     = presc_t'(rand_word() % 32'd4);
        r_val = 32'd4 + rand_word() % 32'd12;
        c_val = rand_word() % (r_val + 32'd1);
        span  = int'(r_val) * (int'(p) + 1);
        high  = 0;
        reg_write(reg_addr(0, `TMR_REG_PRESC), word_t'(p));
        reg_write(reg_addr(0, `TMR_REG_RELOAD), r_val);
        reg_write(reg_addr(0, `TMR_REG_COMPARE), c_val);
        reg_write(reg_addr(0, `TMR_REG_CTRL), 32'h7);   // Start in PWM mode
        wait_cycles(span + 2);
        for (int i = 0; i < span; i++) begin
            if (pwm_out[0])
                high++;
            wait_cycles(1);
        end
        check(word_t'(high), c_val * (word_t'(p) + 32'd1), "PWM high cycles per period");

        reg_write(reg_addr(0, `TMR_REG_CTRL), 32'h4);   // Start held with the mode off
        wait_cycles(1);
        for (int i = 0; i < span; i++) begin
            check(word_t'(pwm_out[0]), 32'h0, "pwm_out with mode off");
            wait_cycles(1);
        end
        stop_all();
    endtask

    task automatic irq_masking();
        count_t n;
        word_t  rd;
        n = 32'd3 + rand_word() % 32'd10;
        reg_write(reg_addr(0, `TMR_REG_RELOAD), n);
        reg_write(reg_addr(0, `TMR_REG_CTRL), 32'h5);
        wait_cycles(n + 2);
        reg_read(STATUS_ADDR, rd);
        check(rd, 32'h1, "status set with irq disabled");
        check(word_t'(irq), 32'h0, "irq low while disabled");

        reg_write(IRQ_EN_ADDR, 32'h1);
        wait_cycles(1);   // irq is registered
        check(word_t'(irq), 32'h1, "irq after enable");
        reg_write(STATUS_ADDR, 32'h1);
        wait_cycles(1);
        check(word_t'(irq), 32'h0, "irq after status clear");

        if (`TMR_NUM_CH > 1) begin
            n = 32'd3 + rand_word() % 32'd10;
            reg_write(reg_addr(1, `TMR_REG_RELOAD), n);
            reg_write(reg_addr(1, `TMR_REG_CTRL), 32'h5);
            wait_cycles(n + 2);
            reg_read(STATUS_ADDR, rd);
            check(rd, 32'h2, "second channel sets only its own status bit");
            check(word_t'(irq), 32'h0, "irq stays low for a disabled channel");
        end
        stop_all();
    endtask

    initial begin
        rst_n       = 1'b0;
        wr_en       = 1'b0;
        rd_en       = 1'b0;
        addr        = '0;
        wdata       = '0;
        cycle_count = 0;
        rng_state   = 32'h1181_685d;

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait_cycles(1);

        readback_regs();
        oneshot_expiry();
        periodic_reload();
        pwm_duty();
        irq_masking();

        $display("Test OK");
        $finish;
    end

endmodule

/* build.f */
+incdir+rtl
rtl/timer_pkg.sv
rtl/timer_reg_decode.sv
rtl/timer_channel.sv
rtl/timer_irq_result.sv
rtl/timer_top.sv
testbench/tb_timer.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -Wno-fatal
TOP       ?= tb_timer
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^Test OK$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
